/* source/rvSettings.svh */
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

// --------------------
// Datapath widths
// --------------------

// Program counter, instruction and immediate width.
`define DATA_WIDTH 32

// Architectural register name, 32 registers.
`define NAME_WIDTH 5

// Enough for every op code in the enum.
`define OP_WIDTH 5

// --------------------
// Fetch queue
// --------------------

// Power of two, at least 2.
`define QUEUE_DEPTH 4

`endif

/* source/rvPkg.sv */
`include "rvSettings.svh"

package rvPkg;

    // --------------------
    // Vector types
    // --------------------

    typedef logic [`DATA_WIDTH-1:0] dataT;   // Pc and immediates.
    typedef logic [31:0]            instT;   // Raw RV32I word.
    typedef logic [`NAME_WIDTH-1:0] nameT;   // Zero means no register.
    typedef logic [6:0]             classT;  // Major opcode field.
    typedef logic [2:0]             funct3T;
    typedef logic [6:0]             funct7T;

    // --------------------
    // Opcode classes
    // --------------------

    localparam classT classNop    = 7'b0000000;
    localparam classT classLui    = 7'b0110111;
    localparam classT classAuipc  = 7'b0010111;
    localparam classT classJal    = 7'b1101111;
    localparam classT classJalr   = 7'b1100111;
    localparam classT classBranch = 7'b1100011;
    localparam classT classLoad   = 7'b0000011;
    localparam classT classStore  = 7'b0100011;
    localparam classT classRegImm = 7'b0010011;
    localparam classT classRegReg = 7'b0110011;

    // Funct7 for the plain and alternate ALU forms.
    localparam funct7T funct7Base = 7'b0000000;
    localparam funct7T funct7Alt  = 7'b0100000;

    // --------------------
    // Op codes
    // --------------------

    typedef enum logic [`OP_WIDTH-1:0] {
        opNop,
        opLui,
        opAuipc,
        opJal,
        opJalr,
        opBeq,
        opBne,
        opBlt,
        opBge,
        opBltu,
        opBgeu,
        opLb,
        opLh,
        opLw,
        opLbu,
        opLhu,
        opSb,
        opSh,
        opSw,
        opAdd,
        opSub,
        opSll,
        opSlt,
        opSltu,
        opXor,
        opSrl,
        opSra,
        opOr,
        opAnd,
        opIllegal
    } opT;

endpackage

/* source/fetchQueue.sv */
`timescale 1ns/1ps
`include "rvSettings.svh"

module fetchQueue (
    input  logic        clk,
    input  logic        rst,
    input  logic        push,
    input  rvPkg::dataT pushPc,
    input  rvPkg::instT pushInst,
    input  logic        stall,
    output logic        full,
    output logic        headValid,
    output rvPkg::dataT headPc,
    output rvPkg::instT headInst
);

    localparam int ptrWidth = $clog2(`QUEUE_DEPTH);
    localparam logic [ptrWidth:0] depthCount = (ptrWidth + 1)'(`QUEUE_DEPTH);

    rvPkg::dataT pcMem [`QUEUE_DEPTH];
    rvPkg::instT instMem [`QUEUE_DEPTH];

    logic [ptrWidth-1:0] rdPtr;
    logic [ptrWidth-1:0] wrPtr;
    logic [ptrWidth:0]   count;
    logic                doPush;
    logic                doPop;

    assign doPush    = push && !full;        // Push while full is dropped.
    assign doPop     = headValid && !stall;  // Decoder takes the head.
    assign full      = (count == depthCount);
    assign headValid = (count != '0);
    assign headPc    = pcMem[rdPtr];
    assign headInst  = instMem[rdPtr];

    // --------------------
    // Storage
    // --------------------

    always_ff @(posedge clk) begin
        if (doPush) begin
            pcMem[wrPtr]   <= pushPc;
            instMem[wrPtr] <= pushInst;
        end
    end

    // --------------------
    // Pointers and count
    // --------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            rdPtr <= '0;
            wrPtr <= '0;
            count <= '0;
        end else begin
            if (doPush) begin
                wrPtr <= wrPtr + 1'b1;  // Wraps at the depth.
            end
            if (doPop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            case ({doPush, doPop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // Both or neither.
            endcase
        end
    end

endmodule

/* source/instDecoder.sv */
`timescale 1ns/1ps

module instDecoder (
    input  logic         clk,
    input  logic         rst,
    input  logic         stall,
    input  logic         headValid,
    input  rvPkg::dataT  headPc,
    input  rvPkg::instT  headInst,
    output rvPkg::opT    opCode,
    output rvPkg::classT opClass,
    output rvPkg::dataT  instAddr,
    output rvPkg::nameT  rs1Name,
    output rvPkg::nameT  rs2Name,
    output rvPkg::nameT  rdName,
    output rvPkg::dataT  immI,
    output rvPkg::dataT  immU,
    output rvPkg::dataT  immJ,
    output rvPkg::dataT  immS,
    output rvPkg::dataT  immB
);

    localparam int dataWidth = $bits(rvPkg::dataT);

    rvPkg::classT  majorOp;
    rvPkg::funct3T funct3;
    rvPkg::funct7T funct7;
    rvPkg::opT     decOp;

    assign majorOp = headInst[6:0];
    assign funct3  = headInst[14:12];
    assign funct7  = headInst[31:25];

    // --------------------
    // Op code lookup
    // --------------------

    always_comb begin
        decOp = rvPkg::opIllegal;  // Anything unmatched.
        case (majorOp)
            rvPkg::classLui:   decOp = rvPkg::opLui;
            rvPkg::classAuipc: decOp = rvPkg::opAuipc;
            rvPkg::classJal:   decOp = rvPkg::opJal;
            rvPkg::classJalr: begin
                if (funct3 == 3'b000) begin
                    decOp = rvPkg::opJalr;
                end
            end
            rvPkg::classBranch: begin
                case (funct3)
                    3'b000:  decOp = rvPkg::opBeq;
                    3'b001:  decOp = rvPkg::opBne;
                    3'b100:  decOp = rvPkg::opBlt;
                    3'b101:  decOp = rvPkg::opBge;
                    3'b110:  decOp = rvPkg::opBltu;
                    3'b111:  decOp = rvPkg::opBgeu;
                    default: decOp = rvPkg::opIllegal;
                endcase
            end
            rvPkg::classLoad: begin
                case (funct3)
                    3'b000:  decOp = rvPkg::opLb;
                    3'b001:  decOp = rvPkg::opLh;
                    3'b010:  decOp = rvPkg::opLw;
                    3'b100:  decOp = rvPkg::opLbu;
                    3'b101:  decOp = rvPkg::opLhu;
                    default: decOp = rvPkg::opIllegal;
                endcase
            end
            rvPkg::classStore: begin
                case (funct3)
                    3'b000:  decOp = rvPkg::opSb;
                    3'b001:  decOp = rvPkg::opSh;
                    3'b010:  decOp = rvPkg::opSw;
                    default: decOp = rvPkg::opIllegal;
                endcase
            end
            rvPkg::classRegImm: begin
                case (funct3)
                    3'b000: decOp = rvPkg::opAdd;
                    3'b010: decOp = rvPkg::opSlt;
                    3'b011: decOp = rvPkg::opSltu;
                    3'b100: decOp = rvPkg::opXor;
                    3'b110: decOp = rvPkg::opOr;
                    3'b111: decOp = rvPkg::opAnd;
                    3'b001: begin
                        if (funct7 == rvPkg::funct7Base) begin
                            decOp = rvPkg::opSll;
                        end
                    end
                    default: begin  // Srli or srai.
                        if (funct7 == rvPkg::funct7Base) begin
                            decOp = rvPkg::opSrl;
                        end else if (funct7 == rvPkg::funct7Alt) begin
                            decOp = rvPkg::opSra;
                        end
                    end
                endcase
            end
            rvPkg::classRegReg: begin
                if (funct7 == rvPkg::funct7Base) begin
                    case (funct3)
                        3'b000:  decOp = rvPkg::opAdd;
                        3'b001:  decOp = rvPkg::opSll;
                        3'b010:  decOp = rvPkg::opSlt;
                        3'b011:  decOp = rvPkg::opSltu;
                        3'b100:  decOp = rvPkg::opXor;
                        3'b101:  decOp = rvPkg::opSrl;
                        3'b110:  decOp = rvPkg::opOr;
                        default: decOp = rvPkg::opAnd;
                    endcase
                end else if (funct7 == rvPkg::funct7Alt) begin
                    if (funct3 == 3'b000) begin
                        decOp = rvPkg::opSub;
                    end else if (funct3 == 3'b101) begin
                        decOp = rvPkg::opSra;
                    end
                end
            end
            default: decOp = rvPkg::opIllegal;  // Fence and system land here.
        endcase
    end

    // --------------------
    // Output register
    // --------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            opCode  <= rvPkg::opNop;
            opClass <= rvPkg::classNop;
        end else if (!stall) begin
            opCode  <= headValid ? decOp : rvPkg::opNop;
            opClass <= headValid ? majorOp : rvPkg::classNop;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            instAddr <= headPc;
            rs1Name  <= headInst[19:15];
            rs2Name  <= headInst[24:20];
            rdName   <= headInst[11:7];
            immI     <= {{(dataWidth - 12){headInst[31]}}, headInst[31:20]};
            immU     <= {headInst[31:12], 12'b0};
            immJ     <= {{(dataWidth - 20){headInst[31]}}, headInst[19:12], headInst[20],
                         headInst[30:21], 1'b0};
            immS     <= {{(dataWidth - 12){headInst[31]}}, headInst[31:25], headInst[11:7]};
            immB     <= {{(dataWidth - 12){headInst[31]}}, headInst[7], headInst[30:25],
                         headInst[11:8], 1'b0};
        end
    end

endmodule

/* source/dispatchStage.sv */
`timescale 1ns/1ps

module dispatchStage (
    input  logic         clk,
    input  logic         rst,
    input  logic         stall,
    input  rvPkg::opT    decOpCode,
    input  rvPkg::classT decOpClass,
    input  rvPkg::dataT  decInstAddr,
    input  rvPkg::nameT  decRs1Name,
    input  rvPkg::nameT  decRs2Name,
    input  rvPkg::nameT  decRdName,
    input  rvPkg::dataT  immI,
    input  rvPkg::dataT  immU,
    input  rvPkg::dataT  immJ,
    input  rvPkg::dataT  immS,
    input  rvPkg::dataT  immB,
    output rvPkg::opT    opCode,
    output rvPkg::classT opClass,
    output rvPkg::dataT  instAddr,
    output rvPkg::dataT  imm,
    output rvPkg::nameT  rs1Name,
    output rvPkg::nameT  rs2Name,
    output rvPkg::nameT  rdName
);

    rvPkg::dataT selImm;
    logic        useRs1;
    logic        useRs2;
    logic        useRd;
    logic        illegal;

    assign illegal = (decOpCode == rvPkg::opIllegal);

    // --------------------
    // Format select
    // --------------------

    always_comb begin
        case (decOpClass)
            rvPkg::classLoad,
            rvPkg::classJalr,
            rvPkg::classRegImm: selImm = immI;
            rvPkg::classLui,
            rvPkg::classAuipc:  selImm = immU;
            rvPkg::classJal:    selImm = immJ;
            rvPkg::classStore:  selImm = immS;
            rvPkg::classBranch: selImm = immB;
            default:            selImm = '0;  // Reg-reg and nop.
        endcase
    end

    assign useRs1 = !(decOpClass == rvPkg::classLui || decOpClass == rvPkg::classAuipc ||
                      decOpClass == rvPkg::classJal);
    assign useRs2 = (decOpClass == rvPkg::classBranch || decOpClass == rvPkg::classStore ||
                     decOpClass == rvPkg::classRegReg);
    assign useRd  = !(decOpClass == rvPkg::classBranch || decOpClass == rvPkg::classStore);

    // --------------------
    // Output register
    // --------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            opCode  <= rvPkg::opNop;
            opClass <= rvPkg::classNop;
        end else if (!stall) begin
            opCode  <= decOpCode;
            opClass <= decOpClass;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            instAddr <= decInstAddr;
            imm      <= illegal ? '0 : selImm;
            rs1Name  <= (useRs1 && !illegal) ? decRs1Name : '0;  // Zero reads as none.
            rs2Name  <= (useRs2 && !illegal) ? decRs2Name : '0;
            rdName   <= (useRd && !illegal) ? decRdName : '0;
        end
    end

endmodule

/* source/decodeFrontTop.sv */
`timescale 1ns/1ps

module decodeFrontTop (
    input  logic         clk,
    input  logic         rst,
    input  logic         push,
    input  rvPkg::dataT  pushPc,
    input  rvPkg::instT  pushInst,
    input  logic         stall,
    output logic         full,
    output rvPkg::opT    opCode,
    output rvPkg::classT opClass,
    output rvPkg::dataT  instAddr,
    output rvPkg::dataT  imm,
    output rvPkg::nameT  rs1Name,
    output rvPkg::nameT  rs2Name,
    output rvPkg::nameT  rdName
);

    logic         headValid;
    rvPkg::dataT  headPc;
    rvPkg::instT  headInst;
    rvPkg::opT    decOpCode;
    rvPkg::classT decOpClass;
    rvPkg::dataT  decInstAddr;
    rvPkg::nameT  decRs1Name;
    rvPkg::nameT  decRs2Name;
    rvPkg::nameT  decRdName;
    rvPkg::dataT  immI;
    rvPkg::dataT  immU;
    rvPkg::dataT  immJ;
    rvPkg::dataT  immS;
    rvPkg::dataT  immB;

    fetchQueue queue0 (
        .clk(clk), .rst(rst), .push(push), .pushPc(pushPc), .pushInst(pushInst),
        .stall(stall), .full(full), .headValid(headValid), .headPc(headPc),
        .headInst(headInst)
    );

    instDecoder decoder0 (
        .clk(clk), .rst(rst), .stall(stall), .headValid(headValid), .headPc(headPc),
        .headInst(headInst), .opCode(decOpCode), .opClass(decOpClass),
        .instAddr(decInstAddr), .rs1Name(decRs1Name), .rs2Name(decRs2Name),
        .rdName(decRdName), .immI(immI), .immU(immU), .immJ(immJ), .immS(immS), .immB(immB)
    );

    dispatchStage dispatch0 (
        .clk(clk), .rst(rst), .stall(stall), .decOpCode(decOpCode), .decOpClass(decOpClass),
        .decInstAddr(decInstAddr), .decRs1Name(decRs1Name), .decRs2Name(decRs2Name),
        .decRdName(decRdName), .immI(immI), .immU(immU), .immJ(immJ), .immS(immS),
        .immB(immB), .opCode(opCode), .opClass(opClass), .instAddr(instAddr), .imm(imm),
        .rs1Name(rs1Name), .rs2Name(rs2Name), .rdName(rdName)
    );

endmodule

/* dv/decodeVectors.svh */
`ifndef DECODE_VECTORS_SVH
`define DECODE_VECTORS_SVH

// Each row holds test name, instruction word, op code, opcode class, rs1, rs2, rd and
// dispatched immediate. Unused register names and illegal encodings expect zero.

function automatic void loadVectors();
    // --------------------
    // Upper immediate and jumps
    // --------------------
    addVector("lui",             32'h123452B7, rvPkg::opLui,     7'h37,  0,  0,  5, 32'h12345000);
    addVector("luiNeg",          32'hFFFFF0B7, rvPkg::opLui,     7'h37,  0,  0,  1, 32'hFFFFF000);
    addVector("auipc",           32'h80000517, rvPkg::opAuipc,   7'h17,  0,  0, 10, 32'h80000000);
    addVector("jalPos",          32'h001000EF, rvPkg::opJal,     7'h6F,  0,  0,  1, 32'h00000800);
    addVector("jalNeg",          32'hFFDFF06F, rvPkg::opJal,     7'h6F,  0,  0,  0, 32'hFFFFFFFC);
    addVector("jalr",            32'h004100E7, rvPkg::opJalr,    7'h67,  2,  0,  1, 32'h00000004);
    // --------------------
    // Branches
    // --------------------
    addVector("beq",             32'h00208463, rvPkg::opBeq,     7'h63,  1,  2,  0, 32'h00000008);
    addVector("bneNeg",          32'hFE4198E3, rvPkg::opBne,     7'h63,  3,  4,  0, 32'hFFFFFFF0);
    addVector("blt",             32'h0062C863, rvPkg::opBlt,     7'h63,  5,  6,  0, 32'h00000010);
    addVector("bge",             32'h0083D263, rvPkg::opBge,     7'h63,  7,  8,  0, 32'h00000004);
    addVector("bltu",            32'h00A4E0E3, rvPkg::opBltu,    7'h63,  9, 10,  0, 32'h00000800);
    addVector("bgeuMin",         32'h80C5F063, rvPkg::opBgeu,    7'h63, 11, 12,  0, 32'hFFFFF000);
    // --------------------
    // Loads and stores
    // --------------------
    addVector("lbNeg",           32'hFFF70683, rvPkg::opLb,      7'h03, 14,  0, 13, 32'hFFFFFFFF);
    addVector("lh",              32'h00281783, rvPkg::opLh,      7'h03, 16,  0, 15, 32'h00000002);
    addVector("lwMax",           32'h7FF92883, rvPkg::opLw,      7'h03, 18,  0, 17, 32'h000007FF);
    addVector("lbu",             32'h000A4983, rvPkg::opLbu,     7'h03, 20,  0, 19, 32'h00000000);
    addVector("lhuMin",          32'h800B5A83, rvPkg::opLhu,     7'h03, 22,  0, 21, 32'hFFFFF800);
    addVector("sb",              32'h017C02A3, rvPkg::opSb,      7'h23, 24, 23,  0, 32'h00000005);
    addVector("shNeg",           32'hFF9D1C23, rvPkg::opSh,      7'h23, 26, 25,  0, 32'hFFFFFFF8);
    addVector("sw",              32'h7FBE2023, rvPkg::opSw,      7'h23, 28, 27,  0, 32'h000007E0);
    // --------------------
    // ALU forms
    // --------------------
    addVector("addiNeg",         32'hFFF10093, rvPkg::opAdd,     7'h13,  2,  0,  1, 32'hFFFFFFFF);
    addVector("slti",            32'h06422193, rvPkg::opSlt,     7'h13,  4,  0,  3, 32'h00000064);
    addVector("sltiu",           32'h00133293, rvPkg::opSltu,    7'h13,  6,  0,  5, 32'h00000001);
    addVector("xori",            32'h55544393, rvPkg::opXor,     7'h13,  8,  0,  7, 32'h00000555);
    addVector("oriNeg",          32'hF0056493, rvPkg::opOr,      7'h13, 10,  0,  9, 32'hFFFFFF00);
    addVector("andi",            32'h0FF67593, rvPkg::opAnd,     7'h13, 12,  0, 11, 32'h000000FF);
    addVector("slli",            32'h00371693, rvPkg::opSll,     7'h13, 14,  0, 13, 32'h00000003);
    addVector("srli",            32'h01F85793, rvPkg::opSrl,     7'h13, 16,  0, 15, 32'h0000001F);
    addVector("srai",            32'h40495893, rvPkg::opSra,     7'h13, 18,  0, 17, 32'h00000404);
    addVector("add",             32'h003100B3, rvPkg::opAdd,     7'h33,  2,  3,  1, 32'h00000000);
    addVector("sub",             32'h40628233, rvPkg::opSub,     7'h33,  5,  6,  4, 32'h00000000);
    addVector("sll",             32'h009413B3, rvPkg::opSll,     7'h33,  8,  9,  7, 32'h00000000);
    addVector("slt",             32'h00C5A533, rvPkg::opSlt,     7'h33, 11, 12, 10, 32'h00000000);
    addVector("sltu",            32'h00F736B3, rvPkg::opSltu,    7'h33, 14, 15, 13, 32'h00000000);
    addVector("xor",             32'h0128C833, rvPkg::opXor,     7'h33, 17, 18, 16, 32'h00000000);
    addVector("srl",             32'h015A59B3, rvPkg::opSrl,     7'h33, 20, 21, 19, 32'h00000000);
    addVector("sra",             32'h418BDB33, rvPkg::opSra,     7'h33, 23, 24, 22, 32'h00000000);
    addVector("or",              32'h01BD6CB3, rvPkg::opOr,      7'h33, 26, 27, 25, 32'h00000000);
    addVector("and",             32'h01EEFE33, rvPkg::opAnd,     7'h33, 29, 30, 28, 32'h00000000);
    // --------------------
    // Unknown encodings
    // --------------------
    addVector("mulIllegal",      32'h023100B3, rvPkg::opIllegal, 7'h33,  0,  0,  0, 32'h00000000);
    addVector("branchF3Illegal", 32'h0020A063, rvPkg::opIllegal, 7'h63,  0,  0,  0, 32'h00000000);
    addVector("ldIllegal",       32'h00013083, rvPkg::opIllegal, 7'h03,  0,  0,  0, 32'h00000000);
    addVector("fenceIllegal",    32'h0FF0000F, rvPkg::opIllegal, 7'h0F,  0,  0,  0, 32'h00000000);
endfunction

`endif

/* dv/decodeFrontTb.sv */
`timescale 1ns/1ps
`include "rvSettings.svh"

module decodeFrontTb;

    logic         clk;
    logic         rst;
    logic         push;
    rvPkg::dataT  pushPc;
    rvPkg::instT  pushInst;
    logic         stall;
    logic         full;
    rvPkg::opT    opCode;
    rvPkg::classT opClass;
    rvPkg::dataT  instAddr;
    rvPkg::dataT  imm;
    rvPkg::nameT  rs1Name;
    rvPkg::nameT  rs2Name;
    rvPkg::nameT  rdName;

    // Table columns filled from the vector file.
    string        nameQ [$];
    rvPkg::instT  instQ [$];
    rvPkg::opT    opQ [$];
    rvPkg::classT classQ [$];
    rvPkg::nameT  rs1Q [$];
    rvPkg::nameT  rs2Q [$];
    rvPkg::nameT  rdQ [$];
    rvPkg::dataT  immQ [$];

    int           expectQ [$];     // Table index of each accepted push.
    int           acceptEdge [$];  // Edge number of each accepted push.
    int           cycle = 0;
    int           captureEdge = 0;
    int           pushCount = 0;
    int           outCount = 0;
    int unsigned  rngInit;
    bit           lastCapture = 1'b1;
    bit           checkLatency = 1'b0;
    rvPkg::opT    prevOp;
    rvPkg::classT prevClass;
    rvPkg::dataT  prevAddr;
    rvPkg::dataT  prevImm;
    rvPkg::nameT  prevRs1;
    rvPkg::nameT  prevRs2;
    rvPkg::nameT  prevRd;

    decodeFrontTop dut0 (
        .clk(clk), .rst(rst), .push(push), .pushPc(pushPc), .pushInst(pushInst),
        .stall(stall), .full(full), .opCode(opCode), .opClass(opClass),
        .instAddr(instAddr), .imm(imm), .rs1Name(rs1Name), .rs2Name(rs2Name),
        .rdName(rdName)
    );

    function automatic void addVector(string test, rvPkg::instT word, rvPkg::opT op,
                                      rvPkg::classT cls, int rs1, int rs2, int rd,
                                      rvPkg::dataT immVal);
        nameQ.push_back(test);
        instQ.push_back(word);
        opQ.push_back(op);
        classQ.push_back(cls);
        rs1Q.push_back(rvPkg::nameT'(rs1));
        rs2Q.push_back(rvPkg::nameT'(rs2));
        rdQ.push_back(rvPkg::nameT'(rd));
        immQ.push_back(immVal);
    endfunction

    `include "decodeVectors.svh"

    task automatic failRun(string line);
        $display("%s", line);
        $display("Simulation failed");
        $fatal(1, "Stopped at the first error.");
    endtask

    task automatic checkValue(string test, string field, rvPkg::dataT expVal,
                              rvPkg::dataT actVal);
        assert (expVal === actVal) else failRun($sformatf("[FAIL] %s %s expected %h actual %h",
                                                          test, field, expVal, actVal));
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;  // 4 ns period.
    end

    // --------------------
    // Monitor
    // --------------------

    always @(posedge clk) begin
        cycle       <= cycle + 1;
        captureEdge <= cycle;
        lastCapture <= !stall;  // Dispatch register loads this edge.
        if (!rst && push && !full) begin
            expectQ.push_back(int'(pushPc[31:2]));
            acceptEdge.push_back(cycle);
            pushCount <= pushCount + 1;
        end
    end

    task automatic checkOutput();
        int    idx;
        int    pushEdge;
        string test;
        assert (expectQ.size() != 0) else failRun("An instruction came out that was never pushed.");
        idx      = expectQ.pop_front();
        pushEdge = acceptEdge.pop_front();
        test     = nameQ[idx];
        assert (opCode == opQ[idx]) else failRun($sformatf("[FAIL] %s opCode expected %s actual %s",
                                                           test, opQ[idx].name(), opCode.name()));
        checkValue(test, "opClass", rvPkg::dataT'(classQ[idx]), rvPkg::dataT'(opClass));
        checkValue(test, "instAddr", rvPkg::dataT'(idx * 4), instAddr);
        checkValue(test, "rs1Name", rvPkg::dataT'(rs1Q[idx]), rvPkg::dataT'(rs1Name));
        checkValue(test, "rs2Name", rvPkg::dataT'(rs2Q[idx]), rvPkg::dataT'(rs2Name));
        checkValue(test, "rdName", rvPkg::dataT'(rdQ[idx]), rvPkg::dataT'(rdName));
        checkValue(test, "imm", immQ[idx], imm);
        if (checkLatency) begin
            checkValue(test, "latency", 2, rvPkg::dataT'(captureEdge - pushEdge));
        end
        outCount++;
    endtask

    task automatic checkHold();
        checkValue("stallHold", "opCode", rvPkg::dataT'(prevOp), rvPkg::dataT'(opCode));
        checkValue("stallHold", "opClass", rvPkg::dataT'(prevClass), rvPkg::dataT'(opClass));
        checkValue("stallHold", "instAddr", prevAddr, instAddr);
        checkValue("stallHold", "imm", prevImm, imm);
        checkValue("stallHold", "rs1Name", rvPkg::dataT'(prevRs1), rvPkg::dataT'(rs1Name));
        checkValue("stallHold", "rs2Name", rvPkg::dataT'(prevRs2), rvPkg::dataT'(rs2Name));
        checkValue("stallHold", "rdName", rvPkg::dataT'(prevRd), rvPkg::dataT'(rdName));
    endtask

    always @(negedge clk) begin
        if (!rst) begin
            if (!lastCapture) begin
                checkHold();
            end else if (opCode != rvPkg::opNop) begin
                checkOutput();
            end
            prevOp    = opCode;
            prevClass = opClass;
            prevAddr  = instAddr;
            prevImm   = imm;
            prevRs1   = rs1Name;
            prevRs2   = rs2Name;
            prevRd    = rdName;
        end
    end

    // --------------------
    // Stimulus
    // --------------------

    task automatic pushTable(bit randomStall);
        int idx;
        idx = 0;
        while (idx < nameQ.size()) begin
            @(posedge clk);
            #1;
            stall = randomStall ? ($urandom % 3 == 0) : 1'b0;
            if (!full) begin
                push     = 1'b1;
                pushPc   = rvPkg::dataT'(idx * 4);
                pushInst = instQ[idx];
                idx++;
            end else begin
                push = 1'b0;  // Wait for the queue to drain.
            end
        end
        @(posedge clk);
        #1;
        push  = 1'b0;
        stall = 1'b0;
    endtask

    task automatic waitDrained();
        while (expectQ.size() != 0) begin
            @(posedge clk);
        end
        repeat (3) @(posedge clk);
        #1;
    endtask

    task automatic fillWhileStalled();
        int k;
        stall = 1'b1;
        for (k = 0; k < `QUEUE_DEPTH; k++) begin
            checkValue("fillStalled", "full", 0, rvPkg::dataT'(full));
            push     = 1'b1;
            pushPc   = rvPkg::dataT'(k * 4);
            pushInst = instQ[k];
            @(posedge clk);
            #1;
        end
        push = 1'b0;
        checkValue("fillStalled", "full", 1, rvPkg::dataT'(full));
        repeat (3) @(posedge clk);  // Nothing moves.
        #1;
        checkValue("fillStalled", "fullHeld", 1, rvPkg::dataT'(full));
        stall = 1'b0;
    endtask

    initial begin
        int limit;
        @(posedge clk);
        limit = 20 * (2 * nameQ.size() + `QUEUE_DEPTH) + 100;
        repeat (limit) @(posedge clk);
        failRun($sformatf("Timeout: the outputs did not drain within %0d cycles.", limit));
    end

    initial begin
        rst      = 1'b1;
        push     = 1'b0;
        pushPc   = '0;
        pushInst = '0;
        stall    = 1'b0;
        rngInit  = $urandom(32'hbf5f);
        loadVectors();
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        @(posedge clk);
        #1;
        checkValue("afterReset", "opCode", rvPkg::dataT'(rvPkg::opNop), rvPkg::dataT'(opCode));
        checkValue("afterReset", "full", 0, rvPkg::dataT'(full));

        checkLatency = 1'b1;  // Back to back with no stall.
        pushTable(1'b0);
        waitDrained();
        checkLatency = 1'b0;
        pushTable(1'b1);
        waitDrained();
        fillWhileStalled();
        waitDrained();

        assert (outCount == pushCount && pushCount == 2 * nameQ.size() + `QUEUE_DEPTH)
            else failRun($sformatf("Pushed %0d instructions but %0d came out.",
                                   pushCount, outCount));
        $display("Simulation passed");
        $finish;
    end

endmodule

/* tb.f */
+incdir+source
+incdir+dv
source/rvPkg.sv
source/fetchQueue.sv
source/instDecoder.sv
source/dispatchStage.sv
source/decodeFrontTop.sv
dv/decodeFrontTb.sv
